//--- hdl/bch_pkg.sv
`default_nettype none

package bch_pkg;

	// Width of the frame and error counters.
	localparam int CNT_W = 16;

	// Frame controller states.
	typedef enum logic [1:0] {
		ST_IDLE,    // Waiting for frame_start.
		ST_RECEIVE, // Accepting bits of a frame.
		ST_DONE     // Last bit taken, frame_end is out.
	} ctrl_state_t;

	// GF(2^m) multiply in polynomial basis, m up to 31.
	// Shift-and-add over the bits of b, reducing a by poly each step.
	function automatic logic [31:0] gf_mul(
		input int          m,
		input logic [31:0] poly,
		input logic [31:0] a,
		input logic [31:0] b
	);
		logic [31:0] acc;
		logic [31:0] x;
		acc = '0;
		x = a;
		for (int i = 0; i < 32; i++) begin
			if (i < m) begin
				if (b[i])
					acc = acc ^ x;
				x = x << 1;
				if (x[m])
					x = x ^ poly; // Poly carries bit m, so this clears it.
			end
		end
		return acc;
	endfunction

	// Alpha to the power e, with alpha the root of poly (element 2).
	function automatic logic [31:0] gf_alpha_pow(
		input int          m,
		input logic [31:0] poly,
		input int          e
	);
		logic [31:0] r;
		int          n;
		r = 32'd1;
		n = e % ((1 << m) - 1); // Alpha has order 2^m - 1.
		for (int i = 0; i < n; i++) begin
			r = gf_mul(m, poly, r, 32'd2);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

//--- hdl/bch_syn_lfsr.sv
`default_nettype none

module bch_syn_lfsr #(
	parameter int         M         = 4,
	parameter logic [M:0] PRIM_POLY = 5'b10011,
	parameter int         POWER     = 1
) (
	input  wire          clk,
	input  wire          rst,
	input  wire          start,   // First bit of a frame.
	input  wire          ce,      // Further bit of the frame.
	input  wire          data_in,
	output logic [M-1:0] syn
);
	import bch_pkg::*;

	// Horner step multiplier, alpha^POWER.
	localparam logic [31:0] MULT = gf_alpha_pow(M, PRIM_POLY, POWER);

	logic [31:0]  prod;
	logic [M-1:0] syn_next;

	// Constant multiplier, reduces to an XOR network.
	assign prod = gf_mul(M, PRIM_POLY, 32'(syn), MULT);

	always_comb begin
		syn_next = prod[M-1:0];
		syn_next[0] = syn_next[0] ^ data_in; // Add the new coefficient.
	end

	always_ff @(posedge clk) begin
		if (rst)
			syn <= '0;
		else if (start)
			syn <= {{(M-1){1'b0}}, data_in};
		else if (ce)
			syn <= syn_next;
	end

	// The controller never issues a start and a continue for the same bit.
	a_start_ce_excl: assert property (@(posedge clk) disable iff (rst)
		!(start && ce));

endmodule

`default_nettype wire

//--- hdl/bch_syndrome.sv
`default_nettype none

module bch_syndrome #(
	parameter int         M         = 4,
	parameter int         T         = 2,
	parameter logic [M:0] PRIM_POLY = 5'b10011
) (
	input  wire              clk,
	input  wire              rst,
	input  wire              syn_start,
	input  wire              syn_ce,
	input  wire              din,
	output wire [2*T*M-1:0]  syndromes // S1 in the low M bits.
);
	import bch_pkg::*;

	logic [M-1:0] odd_syn [T];

	// One Horner register per odd syndrome S(2k+1).
	for (genvar k = 0; k < T; k++) begin : g_odd
		bch_syn_lfsr #(
			.M         (M),
			.PRIM_POLY (PRIM_POLY),
			.POWER     (2 * k + 1)
		) bch_syn_lfsr_inst (
			.clk     (clk),
			.rst     (rst),
			.start   (syn_start),
			.ce      (syn_ce),
			.data_in (din),
			.syn     (odd_syn[k])
		);
	end

	// Place each syndrome S(j), j = 1 .. 2T, in slot j-1.
	for (genvar j = 1; j <= 2 * T; j++) begin : g_slot
		if (j % 2 == 1) begin : g_odd_slot
			assign syndromes[(j-1)*M +: M] = odd_syn[(j-1)/2];
		end else begin : g_even_slot
			// Binary code, so S(2k) = S(k)^2.
			wire [M-1:0] half_syn;
			wire [31:0]  sq;

			assign half_syn = syndromes[(j/2-1)*M +: M];
			assign sq = gf_mul(M, PRIM_POLY, 32'(half_syn), 32'(half_syn));
			assign syndromes[(j-1)*M +: M] = sq[M-1:0];
		end
	end

endmodule

`default_nettype wire

//--- hdl/bch_frame_ctrl.sv
`default_nettype none

module bch_frame_ctrl #(
	parameter int N = 15
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  frame_start,
	input  wire  bit_valid,
	output logic syn_start,
	output logic syn_ce,
	output logic frame_end
);
	import bch_pkg::*;

	localparam int BIT_W = $clog2(N + 1);

	ctrl_state_t      state;
	ctrl_state_t      state_next;
	logic [BIT_W-1:0] bit_cnt; // Bits accepted in the current frame.
	logic             last_bit;

	// A new frame may start in any state, a partial frame is dropped.
	assign syn_start = bit_valid && frame_start;

	// Continuation bits only count while a frame is open.
	assign syn_ce = bit_valid && !frame_start && (state == ST_RECEIVE);

	// N-th bit of the frame accepted in this cycle.
	assign last_bit = (syn_start && (N == 1)) ||
		(syn_ce && (bit_cnt == BIT_W'(N - 1)));

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (syn_start)
					state_next = ST_RECEIVE;
			end
			ST_RECEIVE: state_next = ST_RECEIVE; // A restart stays here, the count starts over.
			ST_DONE: begin
				if (syn_start)
					state_next = ST_RECEIVE; // Back-to-back frame.
				else
					state_next = ST_IDLE;
			end
			default: state_next = ST_IDLE;
		endcase
		if (last_bit)
			state_next = ST_DONE;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			frame_end <= 1'b0;
		end else begin
			state <= state_next;
			frame_end <= last_bit; // One cycle after the N-th bit.
			if (syn_start)
				bit_cnt <= BIT_W'(1);
			else if (syn_ce)
				bit_cnt <= bit_cnt + 1'b1;
			else if (state == ST_DONE)
				bit_cnt <= '0;
		end
	end

	// Frame end is a single-cycle strobe.
	a_frame_end_pulse: assert property (@(posedge clk) disable iff (rst)
		frame_end |=> !frame_end);

	// Counter stays within the frame, and reaches N only once the frame is done.
	a_bit_cnt_range: assert property (@(posedge clk) disable iff (rst)
		(bit_cnt <= N) && ((state == ST_DONE) == (bit_cnt == BIT_W'(N))));

endmodule

`default_nettype wire

//--- hdl/bch_syn_capture.sv
`default_nettype none

module bch_syn_capture #(
	parameter int M = 4,
	parameter int T = 2
) (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         frame_end,
	input  wire  [2*T*M-1:0]            syndromes,
	output logic [2*T*M-1:0]            syn_out,
	output logic                        syn_valid,
	output logic                        error_flag,
	output logic [bch_pkg::CNT_W-1:0]   frame_count,
	output logic [bch_pkg::CNT_W-1:0]   error_count
);

	logic [2*T-1:0] syn_nz; // One flag per syndrome.
	logic           any_nz;

	for (genvar j = 0; j < 2 * T; j++) begin : g_nz
		assign syn_nz[j] = |syndromes[j*M +: M];
	end

	assign any_nz = |syn_nz;

	always_ff @(posedge clk) begin
		if (rst) begin
			syn_valid <= 1'b0;
			error_flag <= 1'b0;
			frame_count <= '0;
			error_count <= '0;
		end else begin
			syn_valid <= frame_end;
			if (frame_end) begin
				error_flag <= any_nz;
				frame_count <= frame_count + 1'b1; // Wraps.
				if (any_nz)
					error_count <= error_count + 1'b1;
			end
		end
	end

	// Latched syndromes. Cleared at reset so the outputs start at zero.
	always_ff @(posedge clk) begin
		if (rst)
			syn_out <= '0;
		else if (frame_end)
			syn_out <= syndromes;
	end

	// A valid result raises the flag exactly when some latched syndrome is nonzero.
	a_flag_matches_syn: assert property (@(posedge clk) disable iff (rst)
		syn_valid |-> (error_flag == (syn_out != '0)));

endmodule

`default_nettype wire

//--- hdl/bch_detector_top.sv
`default_nettype none

module bch_detector_top #(
	parameter int         M         = 4,
	parameter int         T         = 2,
	parameter int         N         = 15,
	parameter logic [M:0] PRIM_POLY = 5'b10011 // x^4 + x + 1.
) (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        frame_start,
	input  wire                        bit_valid,
	input  wire                        din,
	output wire [2*T*M-1:0]            syn_out,
	output wire                        syn_valid,
	output wire                        error_flag,
	output wire [bch_pkg::CNT_W-1:0]   frame_count,
	output wire [bch_pkg::CNT_W-1:0]   error_count
);

	wire             syn_start;
	wire             syn_ce;
	wire             frame_end;
	wire [2*T*M-1:0] syndromes;

	// Codeword cannot be longer than the field order.
	if (N > (1 << M) - 1) begin : g_bad_n
		$error("N exceeds 2^M - 1.");
	end

	bch_frame_ctrl #(
		.N (N)
	) bch_frame_ctrl_inst (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.bit_valid   (bit_valid),
		.syn_start   (syn_start),
		.syn_ce      (syn_ce),
		.frame_end   (frame_end)
	);

	bch_syndrome #(
		.M         (M),
		.T         (T),
		.PRIM_POLY (PRIM_POLY)
	) bch_syndrome_inst (
		.clk       (clk),
		.rst       (rst),
		.syn_start (syn_start),
		.syn_ce    (syn_ce),
		.din       (din),
		.syndromes (syndromes)
	);

	bch_syn_capture #(
		.M (M),
		.T (T)
	) bch_syn_capture_inst (
		.clk         (clk),
		.rst         (rst),
		.frame_end   (frame_end),
		.syndromes   (syndromes),
		.syn_out     (syn_out),
		.syn_valid   (syn_valid),
		.error_flag  (error_flag),
		.frame_count (frame_count),
		.error_count (error_count)
	);

endmodule

`default_nettype wire

//--- verification/bch_tb_model.svh
`ifndef BCH_TB_MODEL_SVH
`define BCH_TB_MODEL_SVH

// Generator of the BCH(15,7) code, x^8 + x^7 + x^6 + x^4 + 1.
localparam logic [8:0] GEN_POLY = 9'h1D1;
localparam int         MSG_K    = 7; // Message bits.

// Alpha to the power e by repeated shifting with reduction.
function automatic logic [M-1:0] ref_alpha_pow(input int e);
	logic [M:0] r;
	int         k;
	r = 1;
	k = e % ((1 << M) - 1);
	for (int i = 0; i < k; i++) begin
		r = r << 1;
		if (r[M])
			r = r ^ PRIM_POLY; // Clears bit M.
	end
	return r[M-1:0];
endfunction

// S(j) = sum over set bits i of alpha^(i*j), bit i is the coefficient of x^i.
function automatic logic [2*T*M-1:0] ref_syndromes(input logic [N-1:0] word);
	logic [2*T*M-1:0] s;
	logic [M-1:0]     term;
	s = '0;
	for (int j = 1; j <= 2 * T; j++) begin
		for (int i = 0; i < N; i++) begin
			if (word[i]) begin
				term = ref_alpha_pow(i * j);
				s[(j-1)*M +: M] = s[(j-1)*M +: M] ^ term;
			end
		end
	end
	return s;
endfunction

// Non-systematic encoding, codeword = m(x) * g(x) over GF(2).
function automatic logic [N-1:0] ref_encode(input logic [MSG_K-1:0] msg);
	logic [N-1:0] c;
	logic [N-1:0] g;
	c = '0;
	g = N'(GEN_POLY);
	for (int i = 0; i < MSG_K; i++) begin
		if (msg[i])
			c = c ^ (g << i);
	end
	return c;
endfunction

// Codeword with one bit flipped at position p.
function automatic logic [N-1:0] ref_flip(input logic [N-1:0] word, input int p);
	logic [N-1:0] e;
	e = '0;
	e[p] = 1'b1;
	return word ^ e;
endfunction

`endif

//--- verification/bch_tb.sv
`default_nettype none

module bch_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int         M              = 4;
	localparam int         T              = 2;
	localparam int         N              = 15;
	localparam logic [M:0] PRIM_POLY      = 5'b10011;
	localparam int         SEED           = 5;
	localparam int         NUM_TESTS      = 12;
	localparam int         TIMEOUT_CYCLES = NUM_TESTS * (2 * N + 10);

	`include "bch_tb_model.svh"

	logic clk;
	logic rst;
	logic frame_start;
	logic bit_valid;
	logic din;
	logic [2*T*M-1:0]          syn_out;
	logic                      syn_valid;
	logic                      error_flag;
	logic [bch_pkg::CNT_W-1:0] frame_count;
	logic [bch_pkg::CNT_W-1:0] error_count;

	// Stimulus and expected results, one row per frame.
	logic [N-1:0]     tbl_word    [NUM_TESTS];
	bit               tbl_gaps    [NUM_TESTS];
	bit               tbl_abort   [NUM_TESTS];
	int               tbl_err_pos [NUM_TESTS]; // -1 when no single-bit error.
	string            tbl_name    [NUM_TESTS];
	logic [2*T*M-1:0] tbl_exp_syn [NUM_TESTS];
	bit               tbl_exp_err [NUM_TESTS];

	int cycle = 0;
	int errors = 0;
	int test_err;
	int tests_failed = 0;
	int exp_frames = 0;
	int exp_errs = 0;
	int last_cyc;

	bch_detector_top #(
		.M (M), .T (T), .N (N), .PRIM_POLY (PRIM_POLY)
	) bch_detector_top_inst (
		.clk (clk), .rst (rst), .frame_start (frame_start), .bit_valid (bit_valid),
		.din (din), .syn_out (syn_out), .syn_valid (syn_valid), .error_flag (error_flag),
		.frame_count (frame_count), .error_count (error_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
			test_err++;
		end
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		for (int i = 0; i < NUM_TESTS; i++) begin
			rnd = $urandom;
			tbl_word[i] = rnd[N-1:0]; // Random unless overwritten below.
			tbl_gaps[i] = (i == 2) || (i == 5) || (i >= 7 && i <= 9);
			tbl_abort[i] = (i == 10) || (i == 11);
			tbl_err_pos[i] = -1;
			tbl_name[i] = "random word";
		end
		tbl_word[0] = '0;
		tbl_name[0] = "all zero";
		tbl_word[1] = ref_encode(7'h01);
		tbl_word[2] = ref_encode(7'h5A);
		tbl_word[3] = ref_encode(7'h7F);
		for (int i = 1; i <= 3; i++)
			tbl_name[i] = "codeword";
		tbl_err_pos[4] = 0;
		tbl_err_pos[5] = 9;
		tbl_err_pos[6] = 14;
		tbl_word[4] = ref_flip(ref_encode(7'h33), 0);
		tbl_word[5] = ref_flip(ref_encode(7'h12), 9);
		tbl_word[6] = ref_flip(ref_encode(7'h00), 14);
		for (int i = 4; i <= 6; i++)
			tbl_name[i] = "single-bit error";
		tbl_name[10] = "restart mid frame";
		tbl_name[11] = "restart mid frame";
		for (int i = 0; i < NUM_TESTS; i++) begin
			tbl_exp_syn[i] = ref_syndromes(tbl_word[i]);
			tbl_exp_err[i] = (tbl_exp_syn[i] != '0);
		end
	endtask

	// Sends the first count bits, highest coefficient first, the first with frame_start.
	task automatic send_bits(input logic [N-1:0] word, input int count, input bit gaps);
		int n;
		for (int i = N - 1; i >= N - count; i--) begin
			n = gaps ? ($urandom % 2) : 0;
			repeat (n) begin
				@(posedge clk);
				bit_valid <= 1'b0;
				frame_start <= 1'b0;
				din <= $urandom; // Must be ignored.
			end
			@(posedge clk);
			bit_valid <= 1'b1;
			frame_start <= (i == N - 1);
			din <= word[i];
		end
	endtask

	// Valid bits without frame_start while idle.
	task automatic send_idle_bits(input int count);
		repeat (count) begin
			@(posedge clk);
			bit_valid <= 1'b1;
			frame_start <= 1'b0;
			din <= $urandom;
		end
	endtask

	task automatic run_test(input int idx);
		logic [31:0] junk;
		bit          got;
		int          k;
		test_err = 0;
		if (idx % 2 == 0)
			send_idle_bits(3);
		if (tbl_abort[idx]) begin
			junk = $urandom;
			send_bits(junk[N-1:0], 4 + ($urandom % 6), 1'b0); // Partial frame, dropped.
		end
		send_bits(tbl_word[idx], N, tbl_gaps[idx]);
		@(negedge clk);
		last_cyc = cycle; // Cycle in which the last bit is on the inputs.
		@(posedge clk);
		bit_valid <= 1'b0;
		frame_start <= 1'b0;
		got = 1'b0;
		k = 0;
		while (!got && k < 20) begin
			@(negedge clk);
			k++;
			if (syn_valid)
				got = 1'b1;
		end
		if (!got) begin
			$display("Test %0d: syn_valid never came after the last bit of the frame", idx);
			errors++;
			test_err++;
		end else begin
			check_value(cycle - last_cyc, 2, "syn_valid latency");
			check_value(syn_out, tbl_exp_syn[idx], "syn_out");
			check_value(error_flag, tbl_exp_err[idx], "error_flag");
			if (tbl_err_pos[idx] >= 0) begin
				check_value(syn_out[M-1:0], ref_alpha_pow(tbl_err_pos[idx]), "S1");
				check_value(syn_out[2*M-1:M], ref_alpha_pow(2 * tbl_err_pos[idx]), "S2");
				check_value(error_flag, 1, "error_flag on single-bit error");
			end
			exp_frames++;
			if (tbl_exp_err[idx])
				exp_errs++;
			check_value(frame_count, exp_frames, "frame_count");
			check_value(error_count, exp_errs, "error_count");
			@(negedge clk);
			check_value(syn_valid, 0, "syn_valid width");
		end
		if (test_err != 0)
			tests_failed++;
		$display("Test %0d (%s): %s", idx, tbl_name[idx], (test_err == 0) ? "ok" : "failed");
	endtask

	initial begin
		rst = 1'b1;
		frame_start = 1'b0;
		bit_valid = 1'b0;
		din = 1'b0;
		void'($urandom(SEED));
		build_table();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value(syn_valid, 0, "syn_valid after reset");
		check_value(syn_out, 0, "syn_out after reset");
		check_value(error_flag, 0, "error_flag after reset");
		check_value(frame_count, 0, "frame_count after reset");
		check_value(error_count, 0, "error_count after reset");
		for (int i = 0; i < NUM_TESTS; i++)
			run_test(i);
		send_idle_bits(4); // Stray bits at the end must change nothing.
		@(posedge clk);
		bit_valid <= 1'b0;
		repeat (3) @(negedge clk);
		check_value(frame_count, exp_frames, "final frame_count");
		check_value(error_count, exp_errs, "final error_count");
		$display("Tests %0d, failed %0d, check errors %0d, frames %0d, errored frames %0d",
			NUM_TESTS, tests_failed, errors, exp_frames, exp_errs);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+verification
hdl/bch_pkg.sv
hdl/bch_syn_lfsr.sv
hdl/bch_syndrome.sv
hdl/bch_frame_ctrl.sv
hdl/bch_syn_capture.sv
hdl/bch_detector_top.sv
verification/bch_tb.sv
